// ==== bench/kcpu_tb.sv ====
// self-checking bench for kcpu_xfer_top; pushes fill the whole stack RAM before the first pull
`timescale 1ns/1ps
`include "kcpu_settings.svh"

module kcpu_tb;
    import kcpu_isa_pkg::*;
    import kcpu_bus_pkg::*;

    localparam int CLK_PERIOD      = 100;
    localparam int AW              = `KCPU_STACK_AW;
    localparam int N_FILL          = 22;  // 22 pushes of 12 bytes cover all 256 bytes
    localparam int N_XFER          = 60;
    localparam int N_PP            = 12;
    localparam int N_RAND          = 300;
    localparam int N_INSTR         = 1 + N_FILL * 4 + 16 + N_XFER + N_PP * 10 + N_RAND;
    localparam int WATCHDOG_CYCLES = (N_INSTR + 4) * 40;
    localparam logic [3:0] CLEAR_CODES [7] = '{`KCPU_RC_D, `KCPU_RC_X, `KCPU_RC_Y,
        `KCPU_RC_U, `KCPU_RC_PC, `KCPU_RC_CC, `KCPU_RC_DP};

    logic   clk;
    logic   rst;
    logic   instr_valid;
    instr_t instr;
    logic   busy;
    logic   done;
    regs_t  regs;

    regs_t  model;                      // expected register state
    logic [7:0] stack_mem [2**AW];      // expected stack RAM
    regs_t  exp_q [$];
    string  name_q [$];
    regs_t  cmp_exp;
    string  cmp_name;

    kcpu_xfer_top uut (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .busy        (busy),
        .done        (done),
        .regs        (regs)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run();
        $display("tests failed");
        $fatal(1, "run stopped at the first error");
    endtask

    function automatic string regs_str(regs_t r);
        return $sformatf("a=%h b=%h dp=%h cc=%h x=%h y=%h u=%h s=%h pc=%h",
                         r.a, r.b, r.dp, r.cc, r.x, r.y, r.u, r.s, r.pc);
    endfunction

    task automatic check_regs(string name, regs_t exp, regs_t act);
        if (act !== exp) begin
            $display("FAILED %s: expected %s actual %s", name, regs_str(exp), regs_str(act));
            abort_run();
        end
    endtask

    task automatic check_latency(string name, int exp, int act);
        if (act != exp) begin
            $display("FAILED %s latency: expected %0d actual %0d cycles", name, exp, act);
            abort_run();
        end
    endtask

    function automatic instr_t make_instr(op_e op, logic pull, logic use_u, logic [7:0] pb,
                                          logic [15:0] imm);
        instr_t in;
        in               = '0;
        in.op            = op;
        in.pull          = pull;
        in.use_u         = use_u;
        in.postbyte.mask = pb;  // raw byte, either view
        in.imm           = imm;
        return in;
    endfunction

    function automatic logic [15:0] read_code(regs_t r, logic [3:0] code);
        case (code)
            `KCPU_RC_D:  return {r.a, r.b};
            `KCPU_RC_X:  return r.x;
            `KCPU_RC_Y:  return r.y;
            `KCPU_RC_U:  return r.u;
            `KCPU_RC_S:  return r.s;
            `KCPU_RC_PC: return r.pc;
            `KCPU_RC_A:  return {8'hFF, r.a}; // 8-bit reads show FF on top
            `KCPU_RC_B:  return {8'hFF, r.b};
            `KCPU_RC_CC: return {8'hFF, r.cc};
            `KCPU_RC_DP: return {8'hFF, r.dp};
            default:     return 16'h0000;
        endcase
    endfunction

    function automatic regs_t write_code(regs_t r, logic [3:0] code, logic [15:0] v);
        case (code)
            `KCPU_RC_D: begin
                r.a = v[15:8];
                r.b = v[7:0];
            end
            `KCPU_RC_X:  r.x  = v;
            `KCPU_RC_Y:  r.y  = v;
            `KCPU_RC_U:  r.u  = v;
            `KCPU_RC_S:  r.s  = v;
            `KCPU_RC_PC: r.pc = v;
            `KCPU_RC_A:  r.a  = v[7:0];
            `KCPU_RC_B:  r.b  = v[7:0];
            `KCPU_RC_CC: r.cc = v[7:0];
            `KCPU_RC_DP: r.dp = v[7:0];
            default: ;
        endcase
        return r;
    endfunction

    // value behind one push/pull mask bit
    function automatic logic [15:0] stacked_value(regs_t r, logic use_u, int idx);
        case (idx)
            MB_CC:    return {8'h00, r.cc};
            MB_A:     return {8'h00, r.a};
            MB_B:     return {8'h00, r.b};
            MB_DP:    return {8'h00, r.dp};
            MB_X:     return r.x;
            MB_Y:     return r.y;
            MB_OTHER: return use_u ? r.s : r.u;
            MB_PC:    return r.pc;
            default:  return 16'h0000;
        endcase
    endfunction

    function automatic regs_t stacked_store(regs_t r, logic use_u, int idx, logic [15:0] w);
        case (idx)
            MB_CC:    r.cc = w[7:0];
            MB_A:     r.a  = w[7:0];
            MB_B:     r.b  = w[7:0];
            MB_DP:    r.dp = w[7:0];
            MB_X:     r.x  = w;
            MB_Y:     r.y  = w;
            MB_OTHER: begin
                if (use_u)
                    r.s = w;
                else
                    r.u = w;
            end
            MB_PC:    r.pc = w;
            default: ;
        endcase
        return r;
    endfunction

    function automatic regs_t stack_model(regs_t r, logic pull, logic use_u, logic [7:0] mask);
        regs_t       nr;
        logic [15:0] sp;
        logic [15:0] w;
        int          idx;
        nr = r;
        sp = use_u ? r.u : r.s;
        for (int k = 0; k < 8; k++) begin
            idx = pull ? k : 7 - k; // pull walks up from CC, push down from PC
            if (mask[idx]) begin
                if (pull) begin
                    w  = {8'h00, stack_mem[sp[AW-1:0]]};
                    sp = sp + 16'd1;
                    if (idx > MB_DP) begin
                        w  = {w[7:0], stack_mem[sp[AW-1:0]]}; // high byte came first
                        sp = sp + 16'd1;
                    end
                    nr = stacked_store(nr, use_u, idx, w);
                end else begin
                    w  = stacked_value(r, use_u, idx);
                    sp = sp - 16'd1;
                    stack_mem[sp[AW-1:0]] = w[7:0];
                    if (idx > MB_DP) begin
                        sp = sp - 16'd1;
                        stack_mem[sp[AW-1:0]] = w[15:8];
                    end
                end
            end
        end
        if (use_u)
            nr.u = sp;
        else
            nr.s = sp;
        return nr;
    endfunction

    // reference: one instruction applied to the model
    function automatic regs_t apply_instr(regs_t r, instr_t in);
        regs_t       nr;
        logic [15:0] sv;
        logic [15:0] dv;
        nr = r;
        sv = read_code(r, in.postbyte.mask[7:4]);
        dv = read_code(r, in.postbyte.mask[3:0]);
        case (in.op)
            OP_LDI: nr = write_code(nr, in.postbyte.mask[3:0], in.imm);
            OP_TFR: nr = write_code(nr, in.postbyte.mask[3:0], sv);
            OP_EXG: begin
                nr = write_code(nr, in.postbyte.mask[7:4], dv); // both from old values
                nr = write_code(nr, in.postbyte.mask[3:0], sv);
            end
            default: nr = stack_model(r, in.pull, in.use_u, in.postbyte.mask);
        endcase
        return nr;
    endfunction

    function automatic int expected_latency(instr_t in);
        int n;
        n = 2;
        if (in.op == OP_PSH) begin
            for (int k = 0; k < 8; k++)
                if (in.postbyte.mask[k]) n += (k > int'(MB_DP)) ? 2 : 1;
        end
        return n;
    endfunction

    task automatic run_instr(string name, instr_t in, output regs_t done_regs);
        int cycles;
        model = apply_instr(model, in);
        exp_q.push_back(model);
        name_q.push_back(name);
        @(posedge clk);
        instr_valid <= 1'b1;
        instr       <= in;
        @(posedge clk);
        instr_valid <= 1'b0;
        cycles = 1;
        while (!done) begin
            @(posedge clk);
            cycles++;
            if (!done && !busy) begin
                $display("%s: busy dropped before done", name);
                abort_run();
            end
        end
        if (busy) begin
            $display("%s: busy still high in the done cycle", name);
            abort_run();
        end
        done_regs = regs;
        check_latency(name, expected_latency(in), cycles - 1);
    endtask

    task automatic check_reset_state();
        regs_t got;
        run_instr("reset_empty_push", make_instr(OP_PSH, 1'b0, 1'b0, 8'h00, 16'h0000), got);
        check_regs("reset_state", '0, got);
    endtask

    task automatic fill_stack();
        regs_t      got;
        logic [3:0] code;
        for (int n = 0; n < N_FILL; n++) begin
            for (int k = 0; k < 3; k++) begin
                code = 4'($urandom());
                if (code == `KCPU_RC_S) code = `KCPU_RC_X; // S stays the fill pointer
                run_instr("fill_load",
                          make_instr(OP_LDI, 1'b0, 1'b0, {4'h0, code}, 16'($urandom())), got);
            end
            run_instr("fill_push", make_instr(OP_PSH, 1'b0, 1'b0, 8'hFF, 16'h0000), got);
        end
    endtask

    task automatic ldi_each_code();
        regs_t got;
        for (int c = 0; c < 16; c++)
            run_instr($sformatf("ldi_code_%0d", c),
                      make_instr(OP_LDI, 1'b0, 1'b0, {4'h0, 4'(c)}, 16'($urandom())), got);
    endtask

    task automatic xfer_pairs();
        regs_t got;
        op_e   op;
        for (int n = 0; n < N_XFER; n++) begin
            op = ($urandom_range(0, 1) == 1) ? OP_EXG : OP_TFR;
            run_instr(op == OP_EXG ? "exg_pair" : "tfr_pair",
                      make_instr(op, 1'b0, 1'b0, 8'($urandom()), 16'h0000), got);
        end
    endtask

    task automatic push_pull_rounds();
        regs_t       got;
        regs_t       saved;
        regs_t       exp;
        logic [15:0] s_start;
        logic [7:0]  mask;
        for (int n = 0; n < N_PP; n++) begin
            s_start = 16'($urandom());
            mask    = 8'($urandom());
            run_instr("pp_load_s",
                      make_instr(OP_LDI, 1'b0, 1'b0, {4'h0, `KCPU_RC_S}, s_start), got);
            saved = model;
            run_instr("pp_push", make_instr(OP_PSH, 1'b0, 1'b0, mask, 16'h0000), got);
            for (int k = 0; k < 7; k++)
                run_instr("pp_clear",
                          make_instr(OP_LDI, 1'b0, 1'b0, {4'h0, CLEAR_CODES[k]}, 16'h0000), got);
            run_instr("pp_pull", make_instr(OP_PSH, 1'b1, 1'b0, mask, 16'h0000), got);
            exp   = '0;
            exp.s = s_start;    // pointer back where it started
            if (mask[MB_CC]) exp.cc = saved.cc;
            if (mask[MB_A]) exp.a = saved.a;
            if (mask[MB_B]) exp.b = saved.b;
            if (mask[MB_DP]) exp.dp = saved.dp;
            if (mask[MB_X]) exp.x = saved.x;
            if (mask[MB_Y]) exp.y = saved.y;
            if (mask[MB_OTHER]) exp.u = saved.u;
            if (mask[MB_PC]) exp.pc = saved.pc;
            check_regs("push_pull_restore", exp, got);
        end
    endtask

    task automatic random_mix();
        regs_t got;
        op_e   op;
        for (int n = 0; n < N_RAND; n++) begin
            op = op_e'(2'($urandom_range(0, 3)));
            run_instr("random_mix", make_instr(op, 1'($urandom()), 1'($urandom()),
                      8'($urandom()), 16'($urandom())), got);
        end
    endtask

    // compares every done against the queued model state
    always @(posedge clk) begin
        if (!rst && done) begin
            if (exp_q.size() == 0) begin
                $display("done strobe with no instruction outstanding");
                abort_run();
            end else begin
                cmp_exp  = exp_q.pop_front();
                cmp_name = name_q.pop_front();
                check_regs(cmp_name, cmp_exp, regs);
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        abort_run();
    end

    initial begin
        void'($urandom(32'h2730));
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        model       = '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        check_reset_state();
        fill_stack();
        ldi_each_code();
        xfer_pairs();
        push_pull_rounds();
        random_mix();
        @(posedge clk);
        if (exp_q.size() != 0) begin
            $display("%0d instructions never signalled done", exp_q.size());
            abort_run();
        end else begin
            $display("all tests passed");
            $finish;
        end
    end

endmodule

// ==== logic/kcpu_bus_pkg.sv ====
// block-to-block buses; a 16-bit register is moved one byte per stack step
`include "kcpu_settings.svh"

package kcpu_bus_pkg;

    typedef struct packed {
        kcpu_isa_pkg::op_e       op;
        logic                    pull;   // only for OP_PSH
        logic                    use_u;  // stack through U, else S
        kcpu_isa_pkg::postbyte_u postbyte;
        logic [`KCPU_ADDR_W-1:0] imm;
    } instr_t;

    // programmer-visible state
    typedef struct packed {
        logic [`KCPU_DATA_W-1:0] a;
        logic [`KCPU_DATA_W-1:0] b;
        logic [`KCPU_DATA_W-1:0] dp;
        logic [`KCPU_DATA_W-1:0] cc;
        logic [`KCPU_ADDR_W-1:0] x;
        logic [`KCPU_ADDR_W-1:0] y;
        logic [`KCPU_ADDR_W-1:0] u;
        logic [`KCPU_ADDR_W-1:0] s;
        logic [`KCPU_ADDR_W-1:0] pc;
    } regs_t;

    typedef struct packed {
        logic                    ld;
        logic                    tfr;
        logic                    exg;
        kcpu_isa_pkg::reg_code_e src;
        kcpu_isa_pkg::reg_code_e dst;
        logic [`KCPU_ADDR_W-1:0] imm;
    } xfer_cmd_t;

    typedef struct packed {
        logic                    valid;
        logic                    pull;
        logic                    use_u;
        logic [7:0]              sel;   // one-hot mask bit
        logic                    hi;    // high half of a 16-bit register
        logic [`KCPU_DATA_W-1:0] data;  // pulled byte
    } stack_step_t;

endpackage

// ==== logic/kcpu_decode.sv ====
// instructions must not arrive while busy; register ops take exactly 2 cycles to done
`timescale 1ns/1ps

module kcpu_decode (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    instr_valid,
    input  kcpu_bus_pkg::instr_t    instr,
    input  logic                    stack_done,
    output kcpu_bus_pkg::xfer_cmd_t cmd,
    output logic                    psh_start,
    output logic                    psh_pull,
    output logic                    psh_use_u,
    output logic [7:0]              psh_mask,
    output logic                    busy,
    output logic                    done
);
    import kcpu_isa_pkg::*;
    import kcpu_bus_pkg::*;

    xfer_cmd_t cmd_d;
    logic      busy_q;
    logic      done_q;

    always_comb begin
        cmd_d     = '0;
        cmd_d.src = instr.postbyte.xfer.src; // ldi only uses dst
        cmd_d.dst = instr.postbyte.xfer.dst;
        cmd_d.imm = instr.imm;
        if (instr_valid) begin
            case (instr.op)
                OP_LDI:  cmd_d.ld  = 1'b1;
                OP_TFR:  cmd_d.tfr = 1'b1;
                OP_EXG:  cmd_d.exg = 1'b1;
                default: ; // stack op goes to the sequencer
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cmd       <= '0;
            psh_start <= 1'b0;
            done_q    <= 1'b0;
            busy_q    <= 1'b0;
        end else begin
            cmd       <= cmd_d;
            psh_start <= instr_valid && instr.op == OP_PSH;
            done_q    <= cmd.ld || cmd.tfr || cmd.exg; // one cycle after the write
            if (instr_valid)
                busy_q <= 1'b1;
            else if (done)
                busy_q <= 1'b0;
        end
    end

    // stack command payload
    always_ff @(posedge clk) begin
        if (instr_valid) begin
            psh_pull  <= instr.pull;
            psh_use_u <= instr.use_u;
            psh_mask  <= instr.postbyte.mask;
        end
    end

    assign done = done_q || stack_done;
    assign busy = busy_q && !done; // low already in the done cycle

    a_no_strobe_busy: assert property (
        @(posedge clk) disable iff (rst) instr_valid |-> !busy
    );

endmodule

// ==== logic/kcpu_isa_pkg.sv ====
// instruction encodings; register codes 6, 7 and 12..15 are unlisted and decode as no register
`include "kcpu_settings.svh"

package kcpu_isa_pkg;

    typedef enum logic [1:0] {
        OP_LDI = 2'd0, // load 16-bit immediate
        OP_TFR = 2'd1,
        OP_EXG = 2'd2,
        OP_PSH = 2'd3  // push or pull, see instr pull flag
    } op_e;

    typedef enum logic [3:0] {
        RC_D  = `KCPU_RC_D,
        RC_X  = `KCPU_RC_X,
        RC_Y  = `KCPU_RC_Y,
        RC_U  = `KCPU_RC_U,
        RC_S  = `KCPU_RC_S,
        RC_PC = `KCPU_RC_PC,
        RC_A  = `KCPU_RC_A,
        RC_B  = `KCPU_RC_B,
        RC_CC = `KCPU_RC_CC,
        RC_DP = `KCPU_RC_DP
    } reg_code_e;

    // push/pull mask bit positions
    localparam int unsigned MB_CC    = 0;
    localparam int unsigned MB_A     = 1;
    localparam int unsigned MB_B     = 2;
    localparam int unsigned MB_DP    = 3; // last 8-bit entry
    localparam int unsigned MB_X     = 4;
    localparam int unsigned MB_Y     = 5;
    localparam int unsigned MB_OTHER = 6; // pointer not used for the stack
    localparam int unsigned MB_PC    = 7;

    typedef struct packed {
        reg_code_e src; // high nibble
        reg_code_e dst; // low nibble
    } xfer_codes_t;

    // one postbyte, two readings
    typedef union packed {
        xfer_codes_t xfer;  // tfr, exg, ldi target
        logic [7:0]  mask;  // push and pull
    } postbyte_u;

endpackage

// ==== logic/kcpu_regs.sv ====
// register file; unlisted codes read zero and write nothing, 8-bit reads get FF on top
`timescale 1ns/1ps

module kcpu_regs (
    input  logic                      clk,
    input  logic                      rst,
    input  kcpu_bus_pkg::xfer_cmd_t   cmd,
    input  kcpu_bus_pkg::stack_step_t step,
    output logic [7:0]                push_byte,
    output logic [15:0]               ptr,
    output kcpu_bus_pkg::regs_t       snapshot
);
    import kcpu_isa_pkg::*;
    import kcpu_bus_pkg::*;

    regs_t       r_q;
    regs_t       nx;
    logic [15:0] src_val;
    logic [15:0] dst_val;
    logic [15:0] wr_val;
    logic [15:0] other;

    function automatic logic [15:0] get_reg(regs_t rf, reg_code_e c);
        case (c)
            RC_D:    return {rf.a, rf.b};
            RC_X:    return rf.x;
            RC_Y:    return rf.y;
            RC_U:    return rf.u;
            RC_S:    return rf.s;
            RC_PC:   return rf.pc;
            RC_A:    return {8'hFF, rf.a};
            RC_B:    return {8'hFF, rf.b};
            RC_CC:   return {8'hFF, rf.cc};
            RC_DP:   return {8'hFF, rf.dp};
            default: return 16'h0000;
        endcase
    endfunction

    function automatic regs_t put_reg(regs_t rf, reg_code_e c, logic [15:0] v);
        case (c)
            RC_D: begin
                rf.a = v[15:8];
                rf.b = v[7:0];
            end
            RC_X:    rf.x  = v;
            RC_Y:    rf.y  = v;
            RC_U:    rf.u  = v;
            RC_S:    rf.s  = v;
            RC_PC:   rf.pc = v;
            RC_A:    rf.a  = v[7:0]; // 8-bit targets take the low byte
            RC_B:    rf.b  = v[7:0];
            RC_CC:   rf.cc = v[7:0];
            RC_DP:   rf.dp = v[7:0];
            default: ;
        endcase
        return rf;
    endfunction

    function automatic logic [7:0] get_half(logic [15:0] w, logic hi);
        return hi ? w[15:8] : w[7:0];
    endfunction

    function automatic logic [15:0] put_half(logic [15:0] w, logic hi, logic [7:0] d);
        if (hi)
            w[15:8] = d;
        else
            w[7:0] = d;
        return w;
    endfunction

    // source and destination muxes
    assign src_val = get_reg(r_q, cmd.src);
    assign dst_val = get_reg(r_q, cmd.dst);
    assign wr_val  = cmd.ld ? cmd.imm : src_val;

    assign ptr   = step.use_u ? r_q.u : r_q.s;
    assign other = step.use_u ? r_q.s : r_q.u;

    always_comb begin
        case (1'b1)
            step.sel[MB_CC]:    push_byte = r_q.cc;
            step.sel[MB_A]:     push_byte = r_q.a;
            step.sel[MB_B]:     push_byte = r_q.b;
            step.sel[MB_DP]:    push_byte = r_q.dp;
            step.sel[MB_X]:     push_byte = get_half(r_q.x, step.hi);
            step.sel[MB_Y]:     push_byte = get_half(r_q.y, step.hi);
            step.sel[MB_OTHER]: push_byte = get_half(other, step.hi);
            step.sel[MB_PC]:    push_byte = get_half(r_q.pc, step.hi);
            default:            push_byte = 8'h00;
        endcase
    end

    // later writes take priority
    always_comb begin
        nx = r_q;
        if (cmd.exg)
            nx = put_reg(nx, cmd.src, dst_val); // old dst value into src
        if (cmd.ld || cmd.tfr || cmd.exg)
            nx = put_reg(nx, cmd.dst, wr_val);

        if (step.valid && step.pull) begin
            case (1'b1)
                step.sel[MB_CC]: nx.cc = step.data;
                step.sel[MB_A]:  nx.a  = step.data;
                step.sel[MB_B]:  nx.b  = step.data;
                step.sel[MB_DP]: nx.dp = step.data;
                step.sel[MB_X]:  nx.x  = put_half(r_q.x, step.hi, step.data);
                step.sel[MB_Y]:  nx.y  = put_half(r_q.y, step.hi, step.data);
                step.sel[MB_OTHER]: begin
                    if (step.use_u)
                        nx.s = put_half(r_q.s, step.hi, step.data);
                    else
                        nx.u = put_half(r_q.u, step.hi, step.data);
                end
                step.sel[MB_PC]: nx.pc = put_half(r_q.pc, step.hi, step.data);
                default: ;
            endcase
        end

        // stack pointer moves once per byte
        if (step.valid) begin
            if (step.use_u)
                nx.u = step.pull ? r_q.u + 16'd1 : r_q.u - 16'd1;
            else
                nx.s = step.pull ? r_q.s + 16'd1 : r_q.s - 16'd1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            r_q <= '0;
        else
            r_q <= nx;
    end

    assign snapshot = r_q;

    // decode and sequencer never overlap
    a_cmd_step_excl: assert property (
        @(posedge clk) disable iff (rst)
        !((cmd.ld || cmd.tfr || cmd.exg) && step.valid)
    );

endmodule

// ==== logic/kcpu_settings.svh ====
// shared widths and register codes; the stack RAM only decodes the low KCPU_STACK_AW pointer bits
`ifndef KCPU_SETTINGS_SVH
`define KCPU_SETTINGS_SVH

// stack RAM depth is 2**KCPU_STACK_AW bytes
`define KCPU_STACK_AW 8

`define KCPU_DATA_W 8
`define KCPU_ADDR_W 16

// 6809 exchange/transfer register codes
`define KCPU_RC_D   4'h0
`define KCPU_RC_X   4'h1
`define KCPU_RC_Y   4'h2
`define KCPU_RC_U   4'h3
`define KCPU_RC_S   4'h4
`define KCPU_RC_PC  4'h5
`define KCPU_RC_A   4'h8
`define KCPU_RC_B   4'h9
`define KCPU_RC_CC  4'hA
`define KCPU_RC_DP  4'hB

`endif

// ==== logic/kcpu_stack_seq.sv ====
// push/pull sequencer; RAM wraps at 2**KCPU_STACK_AW bytes, the pointer's high bits are ignored
`timescale 1ns/1ps
`include "kcpu_settings.svh"

module kcpu_stack_seq (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      psh_start,
    input  logic                      psh_pull,
    input  logic                      psh_use_u,
    input  logic [7:0]                psh_mask,
    input  logic [7:0]                push_byte,
    input  logic [15:0]               ptr,
    output kcpu_bus_pkg::stack_step_t step,
    output logic                      stack_done
);
    import kcpu_isa_pkg::*;
    import kcpu_bus_pkg::*;

    logic [7:0]  ram [2**`KCPU_STACK_AW];
    logic [7:0]  mask_q;    // registers still to move
    logic        pull_q;
    logic        use_u_q;
    logic        second_q;  // second byte of a 16-bit register
    logic [2:0]  pick_idx;
    logic [7:0]  pick;
    logic [7:0]  mask_left;
    logic        step_v;
    logic        last;
    logic [15:0] ptr_dec;

    // push takes the highest bit, pull the lowest
    always_comb begin
        pick_idx = 3'd0;
        if (pull_q) begin
            for (int i = 7; i >= 0; i--)
                if (mask_q[i]) pick_idx = 3'(i);
        end else begin
            for (int i = 0; i < 8; i++)
                if (mask_q[i]) pick_idx = 3'(i);
        end
    end

    assign step_v    = |mask_q;
    assign pick      = step_v ? 8'h01 << pick_idx : 8'h00;
    assign last      = pick_idx <= 3'(MB_DP) || second_q; // 8-bit regs take one step
    assign mask_left = mask_q & ~pick;
    assign ptr_dec   = ptr - 16'd1;

    always_comb begin
        step       = '0;
        step.valid = step_v;
        step.pull  = pull_q;
        step.use_u = use_u_q;
        step.sel   = pick;
        step.hi    = pull_q ? !second_q : second_q; // pull high first, push low first
        step.data  = ram[ptr[`KCPU_STACK_AW-1:0]];
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mask_q     <= 8'h00;
            pull_q     <= 1'b0;
            use_u_q    <= 1'b0;
            second_q   <= 1'b0;
            stack_done <= 1'b0;
        end else begin
            stack_done <= (psh_start && psh_mask == 8'h00) ||
                          (step_v && last && mask_left == 8'h00);
            if (psh_start) begin
                mask_q   <= psh_mask;
                pull_q   <= psh_pull;
                use_u_q  <= psh_use_u;
                second_q <= 1'b0;
            end else if (step_v) begin
                if (last) begin
                    mask_q   <= mask_left;
                    second_q <= 1'b0;
                end else begin
                    second_q <= 1'b1;
                end
            end
        end
    end

    // pre-decrement write
    always_ff @(posedge clk) begin
        if (step_v && !pull_q)
            ram[ptr_dec[`KCPU_STACK_AW-1:0]] <= push_byte;
    end

    a_start_idle: assert property (
        @(posedge clk) disable iff (rst) psh_start |-> mask_q == 8'h00
    );

endmodule

// ==== logic/kcpu_xfer_top.sv ====
// register and stack core; no back-pressure, hold off new instructions while busy
`timescale 1ns/1ps

module kcpu_xfer_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 instr_valid,
    input  kcpu_bus_pkg::instr_t instr,
    output logic                 busy,
    output logic                 done,
    output kcpu_bus_pkg::regs_t  regs
);
    import kcpu_bus_pkg::*;

    xfer_cmd_t   cmd;
    stack_step_t step;
    logic        psh_start;
    logic        psh_pull;
    logic        psh_use_u;
    logic [7:0]  psh_mask;
    logic        stack_done;
    logic [7:0]  push_byte;
    logic [15:0] ptr;

    kcpu_decode u_decode (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .stack_done  (stack_done),
        .cmd         (cmd),
        .psh_start   (psh_start),
        .psh_pull    (psh_pull),
        .psh_use_u   (psh_use_u),
        .psh_mask    (psh_mask),
        .busy        (busy),
        .done        (done)
    );

    kcpu_regs u_regs (
        .clk       (clk),
        .rst       (rst),
        .cmd       (cmd),
        .step      (step),
        .push_byte (push_byte),
        .ptr       (ptr),
        .snapshot  (regs)
    );

    kcpu_stack_seq u_stack_seq (
        .clk        (clk),
        .rst        (rst),
        .psh_start  (psh_start),
        .psh_pull   (psh_pull),
        .psh_use_u  (psh_use_u),
        .psh_mask   (psh_mask),
        .push_byte  (push_byte),
        .ptr        (ptr),
        .step       (step),
        .stack_done (stack_done)
    );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the kcpu testbench with Verilator; the log decides pass or fail
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module kcpu_tb -f vlog.f -o kcpu_sim \
    || { echo "verilator build failed"; exit 1; }
./obj_dir/kcpu_sim > sim.log 2>&1
cat sim.log
test -s sim.log || { echo "simulation produced no log"; exit 1; }
grep -q "tests failed" sim.log && { echo "simulation failed"; exit 1; } || echo "simulation ok"

// ==== vlog.f ====
+incdir+logic
logic/kcpu_isa_pkg.sv
logic/kcpu_bus_pkg.sv
logic/kcpu_decode.sv
logic/kcpu_regs.sv
logic/kcpu_stack_seq.sv
logic/kcpu_xfer_top.sv
bench/kcpu_tb.sv
